/* Bender.yml */
package:
  name: mips_cpu_bus

sources:
  - include_dirs:
      - hw
    files:
      - hw/mips_pkg.sv
      - hw/mips_ctrl_if.sv
      - hw/mips_control.sv
      - hw/mips_pc_unit.sv
      - hw/mips_register_file.sv
      - hw/mips_alu.sv
      - hw/mips_bus_port.sv
      - hw/mips_cpu_bus.sv
  - target: test
    files:
      - testbench/avalon_memory_model.sv
      - testbench/mips_cpu_bus_tb.sv

/* hw/mips_alu.sv */
`default_nettype none

module mips_alu (
  mips_ctrl_if.alu             ctrl,
  input  wire mips_pkg::word_t instr,
  input  wire mips_pkg::word_t rs_data,
  input  wire mips_pkg::word_t rt_data,
  output mips_pkg::word_t      result,
  output logic                 equal
);
  import mips_pkg::*;

  word_t     imm;
  word_t     op_a;
  word_t     op_b;
  reg_addr_t shamt;

  // 16-bit immediate to a word
  assign imm = ctrl.imm_zero_ext ? {16'h0000, instr[15:0]}
                                 : {{16{instr[15]}}, instr[15:0]};

  assign op_a  = rs_data;
  assign op_b  = ctrl.alu_src_imm ? imm : rt_data;
  assign shamt = instr[10:6];  // shifts take rt by the shamt field

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  result = op_a + op_b;
      ALU_SUB:  result = op_a - op_b;
      ALU_AND:  result = op_a & op_b;
      ALU_OR:   result = op_a | op_b;
      ALU_XOR:  result = op_a ^ op_b;
      ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: result = {31'b0, op_a < op_b};
      ALU_SLL:  result = op_b << shamt;
      ALU_SRL:  result = op_b >> shamt;
      ALU_SRA:  result = word_t'($signed(op_b) >>> shamt);  // sign fills from the left
      ALU_LUI:  result = {op_b[15:0], 16'h0000};
      default:  result = '0;
    endcase
  end

  // beq/bne compare the registers, whatever operand b is
  assign equal = (rs_data == rt_data);

endmodule

`default_nettype wire

/* hw/mips_bus_port.sv */
`default_nettype none

module mips_bus_port (
  input  wire logic            clk,
  input  wire logic            reset,
  mips_ctrl_if.bus             ctrl,
  input  wire mips_pkg::word_t readdata,
  input  wire mips_pkg::word_t pc,
  input  wire mips_pkg::word_t alu_result,
  input  wire mips_pkg::word_t rt_data,
  input  wire logic            data_phase,  // MEM state
  output mips_pkg::word_t      instr,
  output mips_pkg::word_t      address,
  output mips_pkg::word_t      writedata,
  output mips_pkg::word_t      wb_data,
  output mips_pkg::reg_addr_t  wb_reg
);
  import mips_pkg::*;

  word_t load_data;

  // instruction register, a nop after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      instr <= '0;
    end else if (ctrl.ir_load) begin
      instr <= readdata;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.dr_load) begin
      load_data <= readdata;  // lw result, used in EXEC
    end
  end

  assign address   = data_phase ? {alu_result[31:2], 2'b00} : pc;  // whole words only
  assign writedata = rt_data;
  assign wb_data   = ctrl.mem_to_reg ? load_data : alu_result;
  assign wb_reg    = ctrl.dest_rt ? instr[20:16] : instr[15:11];

endmodule

`default_nettype wire

/* hw/mips_control.sv */
`default_nettype none

`include "mips_defines.svh"

module mips_control (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            waitrequest,
  input  wire mips_pkg::word_t instr,
  input  wire logic            next_pc_zero,  // from pc unit, checked in EXEC
  mips_ctrl_if.ctrl            ctrl,
  output logic                 read,
  output logic                 write,
  output logic                 active,
  output logic                 data_phase,    // bus address comes from the alu
  output logic                 reg_write_en
);
  import mips_pkg::*;

  cpu_state_t state;
  opcode_t    opcode;
  funct_t     funct;
  logic       is_lw;
  logic       is_sw;
  logic       imm_op;    // i-type writing rt
  logic       rtype_ok;  // function code that writes rd

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];
  assign is_lw  = (opcode == `OP_LW);
  assign is_sw  = (opcode == `OP_SW);
  assign imm_op = opcode inside {`OP_ADDIU, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_XORI,
                                 `OP_LUI, `OP_LW};

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= FETCH;
    end else begin
      case (state)
        FETCH:   if (!waitrequest) state <= MEM;  // ir loads in this cycle
        MEM:     if (!(is_lw || is_sw) || !waitrequest) state <= EXEC;
        EXEC:    state <= next_pc_zero ? HALTED : FETCH;
        default: state <= HALTED;
      endcase
    end
  end

  // bus strobes, held until waitrequest drops
  assign data_phase = (state == MEM);
  assign read       = (state == FETCH) || (data_phase && is_lw);
  assign write      = data_phase && is_sw;
  assign active     = (state != HALTED);

  assign ctrl.ir_load = (state == FETCH) && !waitrequest;
  assign ctrl.dr_load = data_phase && is_lw && !waitrequest;
  assign ctrl.exec    = (state == EXEC);

  // static decode
  assign ctrl.alu_src_imm  = (opcode != `OP_RTYPE);  // branches ignore the alu result
  assign ctrl.dest_rt      = (opcode != `OP_RTYPE);
  assign ctrl.imm_zero_ext = opcode inside {`OP_ANDI, `OP_ORI, `OP_XORI};
  assign ctrl.mem_to_reg   = is_lw;
  assign ctrl.branch_eq    = (opcode == `OP_BEQ);
  assign ctrl.branch_ne    = (opcode == `OP_BNE);
  assign ctrl.jump         = (opcode == `OP_J);
  assign ctrl.jump_reg     = (opcode == `OP_RTYPE) && (funct == `FN_JR);
  assign ctrl.reg_write    = (opcode == `OP_RTYPE) ? rtype_ok : imm_op;
  assign reg_write_en      = ctrl.reg_write && ctrl.exec;  // write only at end of EXEC

  always_comb begin
    ctrl.alu_op = ALU_ADD;  // addiu and lw/sw address
    rtype_ok    = 1'b1;
    case (opcode)
      `OP_SLTI: ctrl.alu_op = ALU_SLT;
      `OP_ANDI: ctrl.alu_op = ALU_AND;
      `OP_ORI:  ctrl.alu_op = ALU_OR;
      `OP_XORI: ctrl.alu_op = ALU_XOR;
      `OP_LUI:  ctrl.alu_op = ALU_LUI;
      `OP_RTYPE: begin
        case (funct)
          `FN_ADDU: ctrl.alu_op = ALU_ADD;
          `FN_SUBU: ctrl.alu_op = ALU_SUB;
          `FN_AND:  ctrl.alu_op = ALU_AND;
          `FN_OR:   ctrl.alu_op = ALU_OR;
          `FN_XOR:  ctrl.alu_op = ALU_XOR;
          `FN_SLT:  ctrl.alu_op = ALU_SLT;
          `FN_SLTU: ctrl.alu_op = ALU_SLTU;
          `FN_SLL:  ctrl.alu_op = ALU_SLL;
          `FN_SRL:  ctrl.alu_op = ALU_SRL;
          `FN_SRA:  ctrl.alu_op = ALU_SRA;
          default:  rtype_ok = 1'b0;  // jr and unknown codes write nothing
        endcase
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hw/mips_cpu_bus.sv */
`default_nettype none

module mips_cpu_bus (
  input  wire logic        clk,
  input  wire logic        reset,
  output logic             active,
  output logic [31:0]      register_v0,
  // avalon-mm master
  output logic [31:0]      address,
  output logic             write,
  output logic             read,
  input  wire logic        waitrequest,
  output logic [31:0]      writedata,
  input  wire logic [31:0] readdata
);
  import mips_pkg::*;

  word_t     instr;
  word_t     pc;
  word_t     rs_data;
  word_t     rt_data;
  word_t     alu_result;
  word_t     wb_data;
  reg_addr_t wb_reg;
  logic      equal;
  logic      next_pc_zero;
  logic      reg_write_en;
  logic      data_phase;

  mips_ctrl_if ctrl_bus ();

  mips_control u_control (
    .clk, .reset, .waitrequest, .instr, .next_pc_zero,
    .ctrl(ctrl_bus.ctrl),
    .read, .write, .active, .data_phase, .reg_write_en
  );

  mips_pc_unit u_pc_unit (
    .clk, .reset, .ctrl(ctrl_bus.pc), .instr, .rs_data, .equal,
    .pc, .next_pc_zero
  );

  mips_register_file u_register_file (
    .clk, .reset,
    .rs_addr(instr[25:21]), .rt_addr(instr[20:16]), .rd_addr(wb_reg),
    .wr_data(wb_data), .wr_en(reg_write_en),
    .rs_data, .rt_data, .register_v0
  );

  mips_alu u_alu (
    .ctrl(ctrl_bus.alu), .instr, .rs_data, .rt_data,
    .result(alu_result), .equal
  );

  mips_bus_port u_bus_port (
    .clk, .reset, .ctrl(ctrl_bus.bus), .readdata, .pc, .alu_result, .rt_data,
    .data_phase, .instr, .address, .writedata, .wb_data, .wb_reg
  );

endmodule

`default_nettype wire

/* hw/mips_ctrl_if.sv */
`default_nettype none

interface mips_ctrl_if;
  import mips_pkg::*;

  alu_op_t alu_op;
  logic    alu_src_imm;   // operand b is the immediate, not rt
  logic    imm_zero_ext;  // andi/ori/xori
  logic    reg_write;     // instruction writes a register (not yet qualified)
  logic    dest_rt;       // i-type destination
  logic    mem_to_reg;    // write back load data
  logic    branch_eq;
  logic    branch_ne;
  logic    jump;          // j with its 26-bit target
  logic    jump_reg;      // jr
  logic    ir_load;
  logic    dr_load;
  logic    exec;          // the one EXEC cycle

  modport ctrl (
    output alu_op, alu_src_imm, imm_zero_ext, reg_write, dest_rt, mem_to_reg,
           branch_eq, branch_ne, jump, jump_reg, ir_load, dr_load, exec
  );

  modport pc (input branch_eq, branch_ne, jump, jump_reg, exec);

  modport alu (input alu_op, alu_src_imm, imm_zero_ext);

  modport bus (input ir_load, dr_load, mem_to_reg, dest_rt);

endinterface

`default_nettype wire

/* hw/mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define MIPS_RESET_VECTOR 32'hBFC00000  // first fetch after reset

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDIU 6'h09
`define OP_SLTI  6'h0A
`define OP_ANDI  6'h0C
`define OP_ORI   6'h0D
`define OP_XORI  6'h0E
`define OP_LUI   6'h0F
`define OP_LW    6'h23
`define OP_SW    6'h2B

// function field of special (opcode 0)
`define FN_SLL  6'h00
`define FN_SRL  6'h02
`define FN_SRA  6'h03
`define FN_JR   6'h08
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_SLT  6'h2A
`define FN_SLTU 6'h2B

`define REG_ZERO 5'd0  // hardwired zero
`define REG_V0   5'd2  // result register shown on register_v0

`endif

/* hw/mips_pc_unit.sv */
`default_nettype none

`include "mips_defines.svh"

module mips_pc_unit (
  input  wire logic            clk,
  input  wire logic            reset,
  mips_ctrl_if.pc              ctrl,
  input  wire mips_pkg::word_t instr,
  input  wire mips_pkg::word_t rs_data,
  input  wire logic            equal,
  output mips_pkg::word_t      pc,
  output logic                 next_pc_zero
);
  import mips_pkg::*;

  word_t pc_plus4;
  word_t branch_target;
  word_t jump_target;
  word_t new_target;   // chosen by the instruction now in EXEC
  word_t held_target;  // waits out the delay slot
  word_t next_pc;
  logic  delay;        // next EXEC redirects to held_target
  logic  taken;

  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00};  // same 256MB region

  assign taken = (ctrl.branch_eq && equal) || (ctrl.branch_ne && !equal) ||
                 ctrl.jump || ctrl.jump_reg;
  assign new_target = ctrl.jump_reg ? rs_data : (ctrl.jump ? jump_target : branch_target);

  assign next_pc      = delay ? held_target : pc_plus4;
  assign next_pc_zero = (next_pc == '0);  // halt condition

  always_ff @(posedge clk) begin
    if (reset) begin
      pc    <= `MIPS_RESET_VECTOR;
      delay <= 1'b0;
    end else if (ctrl.exec) begin
      pc    <= next_pc;
      delay <= taken;  // slot instruction runs first
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.exec && taken) begin
      held_target <= new_target;
    end
  end

endmodule

`default_nettype wire

/* hw/mips_pkg.sv */
`default_nettype none

package mips_pkg;

  typedef logic [31:0] word_t;      // data, address or instruction word
  typedef logic [4:0]  reg_addr_t;  // register number, also shift amount
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;

  // one instruction at a time, no overlap
  typedef enum logic [1:0] {
    FETCH,   // instruction read on the bus
    MEM,     // data access for lw/sw, single idle cycle otherwise
    EXEC,    // register write and pc update
    HALTED   // parked until reset
  } cpu_state_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,   // signed compare
    ALU_SLTU,  // unsigned compare
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_LUI    // immediate into upper half
  } alu_op_t;

endpackage

`default_nettype wire

/* hw/mips_register_file.sv */
`default_nettype none

`include "mips_defines.svh"

module mips_register_file (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire mips_pkg::reg_addr_t rs_addr,
  input  wire mips_pkg::reg_addr_t rt_addr,
  input  wire mips_pkg::reg_addr_t rd_addr,   // write address
  input  wire mips_pkg::word_t     wr_data,
  input  wire logic                wr_en,
  output mips_pkg::word_t          rs_data,
  output mips_pkg::word_t          rt_data,
  output mips_pkg::word_t          register_v0
);
  import mips_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (rd_addr != `REG_ZERO)) begin
      regs[rd_addr] <= wr_data;  // $0 stays zero
    end
  end

  // asynchronous reads
  assign rs_data     = regs[rs_addr];
  assign rt_data     = regs[rt_addr];
  assign register_v0 = regs[`REG_V0];

endmodule

`default_nettype wire

/* mips_cpu_bus.f */
+incdir+hw
hw/mips_pkg.sv
hw/mips_ctrl_if.sv
hw/mips_control.sv
hw/mips_pc_unit.sv
hw/mips_register_file.sv
hw/mips_alu.sv
hw/mips_bus_port.sv
hw/mips_cpu_bus.sv
testbench/avalon_memory_model.sv
testbench/mips_cpu_bus_tb.sv

/* testbench/avalon_memory_model.sv */
`default_nettype none

module avalon_memory_model (
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic [31:0] address,
  input  wire logic        read,
  input  wire logic        write,
  input  wire logic [31:0] writedata,
  output logic             waitrequest,
  output logic [31:0]      readdata
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] PROG_BASE = 32'hBFC00000;

  logic [31:0] prog [16];  // program words, loaded by the testbench
  logic [31:0] data [16];  // data words at 0x00 to 0x3c
  logic [1:0]  stall;      // wait cycles left for the current access
  logic        prog_hit;
  logic        data_hit;

  assign prog_hit = (address[31:6] == PROG_BASE[31:6]);
  assign data_hit = (address[31:6] == 26'd0);

  initial begin
    waitrequest = 1'b1;
    readdata    = 32'h0;
  end

  initial begin
    void'($urandom(32'h5e1a74c9));  // one seed for the run
    forever begin
      @(posedge clk);
      if (reset) begin
        stall <= 2'd0;
        for (int i = 0; i < 16; i++) begin
          data[i] <= 32'h0;
        end
      end else if ((read || write) && !waitrequest) begin
        stall <= 2'($urandom % 3);  // 0 to 2 wait cycles for the next access
        if (write && data_hit) begin
          data[address[5:2]] <= writedata;
        end
      end else if ((read || write) && (stall != 2'd0)) begin
        stall <= stall - 2'd1;
      end
    end
  end

  // responses change on the falling edge, the master samples on the rising one
  always @(negedge clk) begin
    waitrequest <= (read || write) && (stall != 2'd0);
    if (prog_hit) begin
      readdata <= prog[address[5:2]];
    end else if (data_hit) begin
      readdata <= data[address[5:2]];
    end else begin
      readdata <= 32'h0;  // unmapped
    end
  end

endmodule

`default_nettype wire

/* testbench/mips_cpu_bus_tb.sv */
`default_nettype none

module mips_cpu_bus_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS  = 6;
  localparam int PROG_WORDS = 12;
  localparam int HALT_LIMIT = 2000;  // cycles allowed per program

  logic        clk;
  logic        reset;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] address;
  logic        write;
  logic        read;
  logic        waitrequest;
  logic [31:0] writedata;
  logic [31:0] readdata;
  int          errors;
  int          passed;

  string test_name [NUM_TESTS] = '{"alu_arith", "r_logic", "shifts", "immediates",
                                   "mem_round_trip", "branch_delay"};

  // word 0 sits at the reset vector, every program ends with jr $0 and a nop
  logic [31:0] program_table [NUM_TESTS][PROG_WORDS] = '{
    // t0 = 100, t1 = -7, v0 = 93 + 107 + slt 1 + sltu 1
    '{32'h24080064, 32'h2409FFF9, 32'h01091021, 32'h01095023, 32'h004A1021, 32'h0128502A,
      32'h004A1021, 32'h0109502B, 32'h004A1021, 32'h00000008, 32'h00000000, 32'h00000000},
    // lui/ori build t0 = f0f000ff, then and, or, xor
    '{32'h3C08F0F0, 32'h350800FF, 32'h24090F0F, 32'h01091024, 32'h01095025, 32'h01485026,
      32'h004A1025, 32'h00000008, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000},
    // sra 4, srl 28, sll 8 on the same t0
    '{32'h3C08F0F0, 32'h350800FF, 32'h00085103, 32'h00084F02, 32'h00094A00, 32'h01491021,
      32'h00000008, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000},
    // addiu -2, andi 8001, ori 8000, xori ffff, lui 1234, slti -1
    '{32'h2408FFFE, 32'h31098001, 32'h340A8000, 32'h3922FFFF, 32'h004A1021, 32'h3C091234,
      32'h00491021, 32'h290AFFFF, 32'h004A1021, 32'h00000008, 32'h00000000, 32'h00000000},
    // sw cafebabe to 0x14, lw it back and add to v0 = 1
    '{32'h3C08CAFE, 32'h3508BABE, 32'h24090010, 32'h24020001, 32'hAD280004, 32'h8D2A0004,
      32'h004A1021, 32'h00000008, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000},
    // beq taken to word 5, bne untaken, j to word 10, slots add 2 and 8
    '{32'h24020001, 32'h10000003, 32'h24420002, 32'h24420100, 32'h24420200, 32'h14000003,
      32'h24420004, 32'h0BF0000A, 32'h24420008, 32'h24420400, 32'h00000008, 32'h00000000}
  };

  logic [31:0] expected_v0 [NUM_TESTS] = '{32'h000000CA, 32'h00000F0F, 32'hFF0F0F0F,
                                          32'h12350000, 32'hCAFEBABF, 32'h0000000F};
  logic [31:0] expected_word5 [NUM_TESTS] = '{32'h0, 32'h0, 32'h0, 32'h0,
                                             32'hCAFEBABE, 32'h0};  // data at 0x14

  mips_cpu_bus uut (
    .clk, .reset, .active, .register_v0,
    .address, .write, .read, .waitrequest, .writedata, .readdata
  );

  avalon_memory_model mem (
    .clk, .reset, .address, .read, .write, .writedata, .waitrequest, .readdata
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic load_program(input int t);
    for (int i = 0; i < 16; i++) begin
      mem.prog[i] = (i < PROG_WORDS) ? program_table[t][i] : 32'h0;  // nop past the end
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic run_program(input int t);
    int cycles;
    int errors_before;
    errors_before = errors;
    load_program(t);
    apply_reset();
    // first fetch is already on the bus
    assert (active && read && !write) else begin
      $display("%s: wrong strobes after reset, active %b read %b write %b",
               test_name[t], active, read, write);
      errors++;
    end
    assert (address == 32'hBFC00000) else begin
      $display("Fail %s reset address: expected %h, actual %h", test_name[t],
               32'hBFC00000, address);
      errors++;
    end
    cycles = 0;
    while (active && (cycles < HALT_LIMIT)) begin
      @(negedge clk);
      cycles++;
    end
    assert (!active) else begin
      $display("%s: timed out, still active after %0d cycles", test_name[t], HALT_LIMIT);
      errors++;
    end
    if (!active) begin
      assert (register_v0 == expected_v0[t]) else begin
        $display("Fail %s: expected %h, actual %h", test_name[t], expected_v0[t], register_v0);
        errors++;
      end
      assert (mem.data[5] == expected_word5[t]) else begin
        $display("Fail %s data word 0x14: expected %h, actual %h", test_name[t],
                 expected_word5[t], mem.data[5]);
        errors++;
      end
      repeat (4) begin  // halted cpu stays off the bus
        @(negedge clk);
        assert (!active && !read && !write) else begin
          $display("%s: bus strobe raised after halt", test_name[t]);
          errors++;
        end
      end
    end
    if (errors == errors_before) begin
      passed++;
      $display("ok %s: v0 %h after %0d cycles", test_name[t], register_v0, cycles);
    end else begin
      $display("bad %s: %0d errors after %0d cycles", test_name[t], errors - errors_before,
               cycles);
    end
  endtask

  initial begin
    reset  = 1'b1;
    errors = 0;
    passed = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_program(t);
    end
    $display("%0d tests, %0d passed, %0d errors", NUM_TESTS, passed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
